//--- issue_pkg.sv
package issue_pkg;

    // ==============================
    // Widths and counts
    // ==============================
    localparam int ISSUE_WIDTH = 3;
    localparam int XLEN        = 32;
    localparam int ARCH_REGS   = 32;
    localparam int PHYS_REGS   = 64;
    localparam int ARCH_AW     = 5;
    localparam int PHYS_AW     = 6;
    localparam int FREE_INIT   = 32;        // Physical registers free after reset
    localparam int CNT_W       = PHYS_AW + 1; // Free count, 0 to PHYS_REGS
    localparam int OPC_W       = 7;

    // RV32I major opcodes
    localparam logic [OPC_W-1:0] OPC_LUI    = 7'b0110111;
    localparam logic [OPC_W-1:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [OPC_W-1:0] OPC_JAL    = 7'b1101111;
    localparam logic [OPC_W-1:0] OPC_JALR   = 7'b1100111;
    localparam logic [OPC_W-1:0] OPC_BRANCH = 7'b1100011;
    localparam logic [OPC_W-1:0] OPC_LOAD   = 7'b0000011;
    localparam logic [OPC_W-1:0] OPC_STORE  = 7'b0100011;
    localparam logic [OPC_W-1:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [OPC_W-1:0] OPC_OP     = 7'b0110011;

    // ==============================
    // Shared types
    // ==============================
    typedef logic [ARCH_AW-1:0] arch_reg_t;
    typedef logic [PHYS_AW-1:0] phys_reg_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] instr;
        logic [XLEN-1:0] pc;
    } fetch_slot_t;

    typedef struct packed {
        arch_reg_t        rs1;
        arch_reg_t        rs2;
        arch_reg_t        rd;
        logic             rs1_used;
        logic             rs2_used;
        logic             rd_we;
        logic [OPC_W-1:0] opcode;
    } decoded_t;

    typedef struct packed {
        logic [XLEN-1:0]  pc;
        logic [OPC_W-1:0] opcode;
        phys_reg_t        rs1_phys;
        phys_reg_t        rs2_phys;
        phys_reg_t        rd_phys;
        phys_reg_t        old_rd_phys; // Mapping replaced by this uop
        arch_reg_t        rd_arch;
        logic             rd_we;
        logic             rs1_used;
        logic             rs2_used;
        logic             valid;
    } issue_uop_t;

    typedef struct packed {
        logic      valid;
        phys_reg_t phys;   // Register returned to the free list
    } commit_slot_t;

endpackage

//--- rv32i_field_decoder.sv
`timescale 1ns/10ps

module rv32i_field_decoder (
    input  logic [issue_pkg::XLEN-1:0] instr_i,
    output issue_pkg::decoded_t        dec_o
);

    logic [issue_pkg::OPC_W-1:0] opc;

    assign opc = instr_i[6:0];

    // Register fields sit at fixed positions in every RV32I format
    always_comb begin
        logic writes_rd;
        dec_o.opcode   = opc;
        dec_o.rd       = instr_i[11:7];
        dec_o.rs1      = instr_i[19:15];
        dec_o.rs2      = instr_i[24:20];
        dec_o.rs1_used = 1'b0;
        dec_o.rs2_used = 1'b0;
        writes_rd      = 1'b0;

        case (opc)
            issue_pkg::OPC_LUI,
            issue_pkg::OPC_AUIPC,
            issue_pkg::OPC_JAL: begin
                writes_rd = 1'b1;          // No register sources
            end
            issue_pkg::OPC_JALR,
            issue_pkg::OPC_LOAD,
            issue_pkg::OPC_OP_IMM: begin
                writes_rd      = 1'b1;
                dec_o.rs1_used = 1'b1;
            end
            issue_pkg::OPC_BRANCH,
            issue_pkg::OPC_STORE: begin
                dec_o.rs1_used = 1'b1;     // Two sources, no destination
                dec_o.rs2_used = 1'b1;
            end
            issue_pkg::OPC_OP: begin
                writes_rd      = 1'b1;
                dec_o.rs1_used = 1'b1;
                dec_o.rs2_used = 1'b1;
            end
            default: begin
                writes_rd = 1'b0;          // Unknown opcode renames nothing
            end
        endcase

        // Writes to x0 are dropped so x0 never gets a new mapping
        dec_o.rd_we = writes_rd && (dec_o.rd != '0);
    end

endmodule

//--- rename_map_table.sv
`timescale 1ns/10ps

module rename_map_table (
    input  logic                                clk,
    input  logic                                reset,
    input  issue_pkg::fetch_slot_t              slot_i     [issue_pkg::ISSUE_WIDTH],
    input  issue_pkg::decoded_t                 dec_i      [issue_pkg::ISSUE_WIDTH],
    input  issue_pkg::phys_reg_t                new_phys_i [issue_pkg::ISSUE_WIDTH],
    input  logic                                accept_i,
    output logic [issue_pkg::ISSUE_WIDTH-1:0]   alloc_o,
    output issue_pkg::issue_uop_t               uop_o      [issue_pkg::ISSUE_WIDTH]
);

    issue_pkg::phys_reg_t map_q [issue_pkg::ARCH_REGS];

    // ==============================
    // Lookup with in-group bypass
    // ==============================
    always_comb begin
        logic [1:0] n_alloc;
        n_alloc = '0;
        for (int k = 0; k < issue_pkg::ISSUE_WIDTH; k++) begin
            alloc_o[k] = slot_i[k].valid && dec_i[k].rd_we;

            uop_o[k]             = '0;
            uop_o[k].valid       = slot_i[k].valid;
            uop_o[k].pc          = slot_i[k].pc;
            uop_o[k].opcode      = dec_i[k].opcode;
            uop_o[k].rd_arch     = dec_i[k].rd;
            uop_o[k].rd_we       = alloc_o[k];
            uop_o[k].rs1_used    = dec_i[k].rs1_used;
            uop_o[k].rs2_used    = dec_i[k].rs2_used;
            uop_o[k].rs1_phys    = map_q[dec_i[k].rs1];
            uop_o[k].rs2_phys    = map_q[dec_i[k].rs2];
            uop_o[k].old_rd_phys = map_q[dec_i[k].rd];

            // Youngest earlier writer wins, so scan oldest first
            for (int j = 0; j < k; j++) begin
                if (alloc_o[j] && (dec_i[j].rd == dec_i[k].rs1)) begin
                    uop_o[k].rs1_phys = uop_o[j].rd_phys;
                end
                if (alloc_o[j] && (dec_i[j].rd == dec_i[k].rs2)) begin
                    uop_o[k].rs2_phys = uop_o[j].rd_phys;
                end
                if (alloc_o[j] && (dec_i[j].rd == dec_i[k].rd)) begin
                    uop_o[k].old_rd_phys = uop_o[j].rd_phys;
                end
            end

            if (!dec_i[k].rs1_used) uop_o[k].rs1_phys = '0;
            if (!dec_i[k].rs2_used) uop_o[k].rs2_phys = '0;

            // Free registers are handed out in slot order
            if (alloc_o[k]) begin
                uop_o[k].rd_phys = new_phys_i[n_alloc];
                n_alloc          = n_alloc + 2'd1;
            end else begin
                uop_o[k].old_rd_phys = '0;
            end
        end
    end

    // ==============================
    // Mapping update
    // ==============================
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < issue_pkg::ARCH_REGS; i++) begin
                map_q[i] <= issue_pkg::phys_reg_t'(i);   // Identity map
            end
        end else if (accept_i) begin
            // Later slots overwrite earlier ones on the same register
            for (int k = 0; k < issue_pkg::ISSUE_WIDTH; k++) begin
                if (uop_o[k].rd_we) begin
                    map_q[uop_o[k].rd_arch] <= uop_o[k].rd_phys;
                end
            end
        end
    end

endmodule

//--- phys_free_list.sv
`timescale 1ns/10ps

module phys_free_list (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [issue_pkg::ISSUE_WIDTH-1:0] alloc_i,
    input  logic                              pop_i,
    input  issue_pkg::commit_slot_t           commit_i [issue_pkg::ISSUE_WIDTH],
    output issue_pkg::phys_reg_t              head_o   [issue_pkg::ISSUE_WIDTH],
    output logic [issue_pkg::CNT_W-1:0]       count_o
);

    issue_pkg::phys_reg_t              fifo_q [issue_pkg::PHYS_REGS];
    logic [issue_pkg::PHYS_AW-1:0]     head_q;
    logic [issue_pkg::PHYS_AW-1:0]     tail_q;
    logic [issue_pkg::CNT_W-1:0]       count_q;
    logic [issue_pkg::CNT_W-1:0]       n_pop;
    logic [issue_pkg::CNT_W-1:0]       n_push;
    logic [issue_pkg::PHYS_AW-1:0]     wr_ptr [issue_pkg::ISSUE_WIDTH];

    // Next three free registers are valid as far as count allows
    for (genvar g = 0; g < issue_pkg::ISSUE_WIDTH; g++) begin : g_head
        assign head_o[g] = fifo_q[issue_pkg::PHYS_AW'(head_q + g)];   // Wraps around the ring
    end

    assign count_o = count_q;

    always_comb begin
        n_pop  = '0;
        n_push = '0;
        for (int k = 0; k < issue_pkg::ISSUE_WIDTH; k++) begin
            if (pop_i && alloc_i[k]) n_pop = n_pop + 1'b1;
            wr_ptr[k] = tail_q + n_push[issue_pkg::PHYS_AW-1:0]; // Packed behind earlier pushes
            if (commit_i[k].valid) n_push = n_push + 1'b1;
        end
    end

    // ==============================
    // Queue state
    // ==============================
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            head_q  <= '0;
            tail_q  <= issue_pkg::PHYS_AW'(issue_pkg::FREE_INIT);
            count_q <= issue_pkg::CNT_W'(issue_pkg::FREE_INIT);
            // Registers 32 to 63 first, the rest of the ring is don't care
            for (int i = 0; i < issue_pkg::PHYS_REGS; i++) begin
                fifo_q[i] <= issue_pkg::phys_reg_t'(issue_pkg::FREE_INIT + i);
            end
        end else begin
            for (int k = 0; k < issue_pkg::ISSUE_WIDTH; k++) begin
                if (commit_i[k].valid) begin
                    fifo_q[wr_ptr[k]] <= commit_i[k].phys;
                end
            end
            head_q  <= head_q + n_pop[issue_pkg::PHYS_AW-1:0];
            tail_q  <= tail_q + n_push[issue_pkg::PHYS_AW-1:0];
            count_q <= count_q + n_push - n_pop;   // Pop and push in one edge
        end
    end

endmodule

//--- issue_slot_reg.sv
`timescale 1ns/10ps

module issue_slot_reg (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush_i,
    input  logic                  load_i,
    input  issue_pkg::issue_uop_t uop_i [issue_pkg::ISSUE_WIDTH],
    input  logic                  dispatch_ready_i,
    output logic                  valid_o,
    output issue_pkg::issue_uop_t uop_o [issue_pkg::ISSUE_WIDTH]
);

    logic                  valid_q;
    issue_pkg::issue_uop_t uop_q [issue_pkg::ISSUE_WIDTH];

    // ==============================
    // Group valid flag
    // ==============================
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;                 // Held group is dropped
        end else if (load_i) begin
            valid_q <= 1'b1;
        end else if (dispatch_ready_i) begin
            valid_q <= 1'b0;                 // Group left, nothing behind it
        end
    end

    // Payload only moves on a load, so a stalled group holds still
    always_ff @(posedge clk) begin
        if (load_i) begin
            for (int k = 0; k < issue_pkg::ISSUE_WIDTH; k++) begin
                uop_q[k] <= uop_i[k];
            end
        end
    end

    assign valid_o = valid_q;

    always_comb begin
        for (int k = 0; k < issue_pkg::ISSUE_WIDTH; k++) begin
            uop_o[k] = uop_q[k];
        end
    end

endmodule

//--- issue_stage.sv
`timescale 1ns/10ps

module issue_stage (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    flush_i,
    input  logic                    bubble_i,
    input  logic                    group_valid_i,
    input  issue_pkg::fetch_slot_t  slots_i  [issue_pkg::ISSUE_WIDTH],
    output logic                    group_ready_o,
    input  issue_pkg::commit_slot_t commit_i [issue_pkg::ISSUE_WIDTH],
    output logic                    dispatch_valid_o,
    input  logic                    dispatch_ready_i,
    output issue_pkg::issue_uop_t   uops_o   [issue_pkg::ISSUE_WIDTH]
);

    issue_pkg::decoded_t              dec      [issue_pkg::ISSUE_WIDTH];
    issue_pkg::phys_reg_t             free_reg [issue_pkg::ISSUE_WIDTH];
    issue_pkg::issue_uop_t            uop_next [issue_pkg::ISSUE_WIDTH];
    logic [issue_pkg::ISSUE_WIDTH-1:0] alloc;
    logic [issue_pkg::CNT_W-1:0]      free_cnt;
    logic                             accept;

    // ==============================
    // Intake handshake
    // ==============================
    // Room for a full group, a free output register, no stall or flush
    assign group_ready_o = (free_cnt >= issue_pkg::ISSUE_WIDTH) &&
                           (!dispatch_valid_o || dispatch_ready_i) &&
                           !bubble_i && !flush_i;
    assign accept = group_valid_i && group_ready_o;

    for (genvar g = 0; g < issue_pkg::ISSUE_WIDTH; g++) begin : g_dec
        rv32i_field_decoder i_dec (
            .instr_i (slots_i[g].instr),
            .dec_o   (dec[g])
        );
    end

    rename_map_table i_rat (
        .clk        (clk),
        .reset      (reset),
        .slot_i     (slots_i),
        .dec_i      (dec),
        .new_phys_i (free_reg),
        .accept_i   (accept),
        .alloc_o    (alloc),
        .uop_o      (uop_next)
    );

    phys_free_list i_free (
        .clk      (clk),
        .reset    (reset),
        .alloc_i  (alloc),
        .pop_i    (accept),     // Pops only for an accepted group
        .commit_i (commit_i),
        .head_o   (free_reg),
        .count_o  (free_cnt)
    );

    issue_slot_reg i_slot (
        .clk              (clk),
        .reset            (reset),
        .flush_i          (flush_i),
        .load_i           (accept),
        .uop_i            (uop_next),
        .dispatch_ready_i (dispatch_ready_i),
        .valid_o          (dispatch_valid_o),
        .uop_o            (uops_o)
    );

endmodule

//--- tb_issue_stage.sv
`timescale 1ns/10ps

module tb_issue_stage;

    logic                    clk;
    logic                    reset;
    logic                    flush;
    logic                    bubble;
    logic                    group_valid;
    logic                    group_ready;
    logic                    dispatch_valid;
    logic                    dispatch_ready;
    issue_pkg::fetch_slot_t  slots  [issue_pkg::ISSUE_WIDTH];
    issue_pkg::commit_slot_t commit [issue_pkg::ISSUE_WIDTH];
    issue_pkg::issue_uop_t   uops   [issue_pkg::ISSUE_WIDTH];
    logic [issue_pkg::ISSUE_WIDTH*$bits(issue_pkg::issue_uop_t)-1:0] uops_flat;

    // Reference model state
    issue_pkg::phys_reg_t    map_m   [issue_pkg::ARCH_REGS];
    issue_pkg::phys_reg_t    free_m  [$];
    issue_pkg::phys_reg_t    to_free [$];      // Replaced mappings, ready to be committed
    issue_pkg::issue_uop_t   exp_uop [issue_pkg::ISSUE_WIDTH];
    logic                    exp_valid;
    logic                    acc_edge;         // Group taken at the coming rising edge
    int                      errors;
    int                      accepted;
    int                      dispatched;
    int                      flushed;
    integer                  seed;
    logic [31:0]             pc_next;

    issue_stage i_dut (
        .clk              (clk),
        .reset            (reset),
        .flush_i          (flush),
        .bubble_i         (bubble),
        .group_valid_i    (group_valid),
        .slots_i          (slots),
        .group_ready_o    (group_ready),
        .commit_i         (commit),
        .dispatch_valid_o (dispatch_valid),
        .dispatch_ready_i (dispatch_ready),
        .uops_o           (uops)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    assign uops_flat = {uops[2], uops[1], uops[0]};

    // ==============================
    // Protocol assertions
    // ==============================
    hold_check: assert property (@(posedge clk) disable iff (!reset)
        dispatch_valid && !dispatch_ready && !flush |=> dispatch_valid && $stable(uops_flat))
    else begin
        errors++;
        $display("CHECK FAILED uops_o not held under back-pressure, dispatch_valid_o %h",
                 dispatch_valid);
    end

    flush_check: assert property (@(posedge clk) disable iff (!reset)
        flush |=> !dispatch_valid)
    else begin
        errors++;
        $display("CHECK FAILED dispatch_valid_o %h after flush", dispatch_valid);
    end

    bubble_check: assert property (@(posedge clk) disable iff (!reset)
        bubble |-> !group_ready)
    else begin
        errors++;
        $display("CHECK FAILED group_ready_o %h during bubble", group_ready);
    end

    // ==============================
    // Reference model
    // ==============================
    function automatic logic [31:0] make_instr(input logic [6:0] opc,
                                               input issue_pkg::arch_reg_t rd,
                                               input issue_pkg::arch_reg_t rs1,
                                               input issue_pkg::arch_reg_t rs2);
        return {7'b0, rs2, rs1, 3'b0, rd, opc};
    endfunction

    task automatic rename_group();
        logic [6:0]           opc;
        issue_pkg::arch_reg_t rd;
        logic                 writes;
        for (int k = 0; k < issue_pkg::ISSUE_WIDTH; k++) begin
            opc    = slots[k].instr[6:0];
            rd     = slots[k].instr[11:7];
            writes = opc inside {issue_pkg::OPC_LUI, issue_pkg::OPC_AUIPC, issue_pkg::OPC_JAL,
                                 issue_pkg::OPC_JALR, issue_pkg::OPC_LOAD,
                                 issue_pkg::OPC_OP_IMM, issue_pkg::OPC_OP};
            exp_uop[k]          = '0;
            exp_uop[k].valid    = slots[k].valid;
            exp_uop[k].pc       = slots[k].pc;
            exp_uop[k].opcode   = opc;
            exp_uop[k].rd_arch  = rd;
            exp_uop[k].rs1_used = opc inside {issue_pkg::OPC_JALR, issue_pkg::OPC_BRANCH,
                                              issue_pkg::OPC_LOAD, issue_pkg::OPC_STORE,
                                              issue_pkg::OPC_OP_IMM, issue_pkg::OPC_OP};
            exp_uop[k].rs2_used = opc inside {issue_pkg::OPC_BRANCH, issue_pkg::OPC_STORE,
                                              issue_pkg::OPC_OP};
            // The map already holds earlier slots of this group
            if (exp_uop[k].rs1_used) exp_uop[k].rs1_phys = map_m[slots[k].instr[19:15]];
            if (exp_uop[k].rs2_used) exp_uop[k].rs2_phys = map_m[slots[k].instr[24:20]];
            if (slots[k].valid && writes && rd != '0) begin
                exp_uop[k].rd_we       = 1'b1;
                exp_uop[k].rd_phys     = free_m.pop_front();
                exp_uop[k].old_rd_phys = map_m[rd];
                to_free.push_back(map_m[rd]);
                map_m[rd] = exp_uop[k].rd_phys;
            end
        end
        exp_valid = 1'b1;
    endtask

    task automatic compare_group();
        for (int k = 0; k < issue_pkg::ISSUE_WIDTH; k++) begin
            assert (exp_uop[k].valid ? (uops[k] == exp_uop[k]) : !uops[k].valid) else begin
                errors++;
                $display("CHECK FAILED uops_o[%0d] got %h expected %h", k, uops[k], exp_uop[k]);
            end
        end
    endtask

    // Outputs are settled at the falling edge, inputs change only after the rising one
    always @(negedge clk) begin
        logic ready_exp;
        if (!reset) begin
            acc_edge = 1'b0;
        end else begin
            ready_exp = (free_m.size() >= issue_pkg::ISSUE_WIDTH) &&
                        (!exp_valid || dispatch_ready) && !bubble && !flush;
            assert (group_ready == ready_exp) else begin
                errors++;
                $display("CHECK FAILED group_ready_o got %h expected %h", group_ready, ready_exp);
            end
            assert (dispatch_valid == exp_valid) else begin
                errors++;
                $display("CHECK FAILED dispatch_valid_o got %h expected %h",
                         dispatch_valid, exp_valid);
            end
            if (exp_valid) compare_group();
            acc_edge = group_valid && group_ready;
            if (flush && exp_valid) flushed++;
            else if (exp_valid && dispatch_ready) dispatched++;
            if (acc_edge) begin
                rename_group();
                accepted++;
            end else if (flush || dispatch_ready) begin
                exp_valid = 1'b0;
            end
            for (int k = 0; k < issue_pkg::ISSUE_WIDTH; k++) begin
                if (commit[k].valid) free_m.push_back(commit[k].phys);   // Slot 0 first
            end
        end
    end

    // ==============================
    // Stimulus helpers
    // ==============================
    function automatic logic [6:0] pick_opcode(input int n);
        case (n)
            0:       return issue_pkg::OPC_LUI;
            1:       return issue_pkg::OPC_AUIPC;
            2:       return issue_pkg::OPC_JAL;
            3:       return issue_pkg::OPC_JALR;
            4:       return issue_pkg::OPC_BRANCH;
            5:       return issue_pkg::OPC_LOAD;
            6:       return issue_pkg::OPC_STORE;
            7:       return issue_pkg::OPC_OP_IMM;
            8:       return issue_pkg::OPC_OP;
            default: return 7'b1111111;         // Not an RV32I opcode
        endcase
    endfunction

    task automatic random_slots(input logic [4:0] reg_mask, input logic all_write);
        logic [6:0]           opc;
        issue_pkg::arch_reg_t rd;
        for (int k = 0; k < issue_pkg::ISSUE_WIDTH; k++) begin
            opc = all_write ? issue_pkg::OPC_OP : pick_opcode({$random(seed)} % 10);
            rd  = all_write ? 5'(1 + {$random(seed)} % 31) : (5'($random(seed)) & reg_mask);
            slots[k].valid = all_write || (($random(seed) & 3) != 0);
            slots[k].pc    = pc_next;
            slots[k].instr = make_instr(opc, rd, 5'($random(seed)) & reg_mask,
                                        5'($random(seed)) & reg_mask);
            pc_next        = pc_next + 32'd4;
        end
    endtask

    task automatic report_and_stop();
        $display("Errors %0d, groups accepted %0d, dispatched %0d, flushed %0d",
                 errors, accepted, dispatched, flushed);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    endtask

    // Returns 1 ns after the edge that took the group
    task automatic wait_accept();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!acc_edge && n < 50);
        if (!acc_edge) begin
            errors++;
            $display("No group was accepted within %0d cycles, stopping", n);
            report_and_stop();
        end else begin
            #1;
        end
    endtask

    task automatic commit_regs(input int n);
        for (int k = 0; k < issue_pkg::ISSUE_WIDTH; k++) begin
            commit[k] = '0;
            if (k < n && to_free.size() > 0) begin
                commit[k].valid = 1'b1;
                commit[k].phys  = to_free.pop_front();
            end
        end
        @(posedge clk);
        #1;
        for (int k = 0; k < issue_pkg::ISSUE_WIDTH; k++) commit[k] = '0;
    endtask

    // ==============================
    // Test sequence
    // ==============================
    initial begin
        int held;
        seed       = 32'hcb5f;
        errors     = 0;
        accepted   = 0;
        dispatched = 0;
        flushed    = 0;
        pc_next    = 32'h0000_1000;
        exp_valid  = 1'b0;
        acc_edge   = 1'b0;
        for (int i = 0; i < issue_pkg::ARCH_REGS; i++) map_m[i] = issue_pkg::phys_reg_t'(i);
        for (int i = issue_pkg::FREE_INIT; i < issue_pkg::PHYS_REGS; i++) begin
            free_m.push_back(issue_pkg::phys_reg_t'(i));
        end
        reset          = 1'b0;
        flush          = 1'b0;
        bubble         = 1'b0;
        group_valid    = 1'b0;
        dispatch_ready = 1'b0;
        for (int k = 0; k < issue_pkg::ISSUE_WIDTH; k++) begin
            slots[k]  = '0;
            commit[k] = '0;
        end
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b1;
        @(negedge clk);
        assert (!dispatch_valid && group_ready) else begin
            errors++;
            $display("CHECK FAILED dispatch_valid_o %h group_ready_o %h after reset",
                     dispatch_valid, group_ready);
        end

        // Every other random group stays on x0..x7 so bypasses are common
        @(posedge clk);
        #1;
        dispatch_ready = 1'b1;
        for (int g = 0; g < 40; g++) begin
            random_slots((g % 2 == 0) ? 5'h07 : 5'h1f, 1'b0);
            group_valid = 1'b1;
            wait_accept();
            group_valid = 1'b0;
            commit_regs(3);
        end

        // In-group chain on x5 and x6
        for (int k = 0; k < issue_pkg::ISSUE_WIDTH; k++) begin
            slots[k].valid = 1'b1;
            slots[k].pc    = pc_next + 32'(4 * k);
        end
        slots[0].instr = make_instr(issue_pkg::OPC_OP, 5'd5, 5'd1, 5'd2);
        slots[1].instr = make_instr(issue_pkg::OPC_OP, 5'd6, 5'd5, 5'd5);  // Reads slot 0
        slots[2].instr = make_instr(issue_pkg::OPC_OP, 5'd5, 5'd6, 5'd5);  // Rewrites x5
        group_valid = 1'b1;
        wait_accept();

        // Back-pressure holds the chain group while the next one waits
        dispatch_ready = 1'b0;
        random_slots(5'h1f, 1'b0);
        held = accepted;
        repeat (6) @(posedge clk);
        #1;
        assert (accepted == held) else begin
            errors++;
            $display("A group was accepted while dispatch was stalled");
        end
        dispatch_ready = 1'b1;
        wait_accept();

        // Drain the free list with no commits
        while (free_m.size() >= issue_pkg::ISSUE_WIDTH) begin
            random_slots(5'h1f, 1'b1);
            wait_accept();
        end
        random_slots(5'h1f, 1'b1);
        held = accepted;
        repeat (4) @(posedge clk);
        #1;
        assert (accepted == held) else begin
            errors++;
            $display("A group was accepted with fewer than three free registers");
        end
        commit_regs(3);
        wait_accept();                          // Takes the registers just returned
        group_valid = 1'b0;
        commit_regs(3);                         // Refill for the flush and bubble groups
        commit_regs(3);

        // Flush a held group, then a bubble
        dispatch_ready = 1'b0;
        random_slots(5'h1f, 1'b0);
        group_valid = 1'b1;
        wait_accept();
        random_slots(5'h1f, 1'b0);
        flush = 1'b1;
        held  = accepted;
        @(posedge clk);
        #1;
        flush          = 1'b0;
        bubble         = 1'b1;
        dispatch_ready = 1'b1;
        @(posedge clk);
        #1;
        bubble = 1'b0;
        assert (accepted == held) else begin
            errors++;
            $display("A group was accepted during flush or bubble");
        end
        wait_accept();
        group_valid = 1'b0;
        repeat (3) @(posedge clk);

        assert (!exp_valid && accepted == dispatched + flushed) else begin
            errors++;
            $display("Group count mismatch, a group was lost or duplicated");
        end
        report_and_stop();
    end

endmodule

//--- tb.f
issue_pkg.sv
rv32i_field_decoder.sv
rename_map_table.sv
phys_free_list.sv
issue_slot_reg.sv
issue_stage.sv
tb_issue_stage.sv

//--- Makefile
# Verilator build and run for the rename-and-issue stage

VERILATOR ?= verilator
TOP       ?= tb_issue_stage
RTL_TOP   ?= issue_stage
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= ALL TESTS PASSED
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall
RTL_SRCS  ?= issue_pkg.sv rv32i_field_decoder.sv rename_map_table.sv \
             phys_free_list.sv issue_slot_reg.sv issue_stage.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
